// ==== Bender.yml ====
package:
  name: periph_uart

sources:
  - periph_pkg.sv
  - uart_pkg.sv
  - hid_decode.sv
  - uart_fifo.sv
  - uart_serial.sv
  - uart_channel.sv
  - hid_read_mux.sv
  - periph_top.sv
  - target: simulation
    files:
      - tb_periph.sv

// ==== hid_decode.sv ====
// ======================================
// peripheral bus slot decoder
// qualifies writes and fans them out as
// one-hot strobes, one per bus slot
// ======================================
`timescale 1ns/1ps

module hid_decode (
   input  logic                              hid_en_i,
   input  logic [periph_pkg::HID_BE_W-1:0]   hid_we_i,
   input  logic [periph_pkg::HID_ADDR_W-1:0] hid_addr_i,
   output logic [periph_pkg::HID_SLOTS-1:0]  slot_wr_o,
   output periph_pkg::slot_idx_t             slot_sel_o
);

   logic wr_req;

   assign wr_req     = hid_en_i & (|hid_we_i);  // any byte lane counts as a write
   assign slot_sel_o = hid_addr_i[periph_pkg::SLOT_MSB:periph_pkg::SLOT_LSB];

   always_comb
   begin
      for (int i = 0; i < periph_pkg::HID_SLOTS; i++)
      begin
         slot_wr_o[i] = wr_req & (slot_sel_o == periph_pkg::slot_idx_t'(i));
      end
   end

endmodule

// ==== hid_read_mux.sv ====
// ======================================
// peripheral bus read return
// OR-combines the addressed channel word,
// zero for slots with no uart behind them
// ======================================
`timescale 1ns/1ps

module hid_read_mux #(
   parameter int NUM_UARTS = 2
) (
   input  periph_pkg::slot_idx_t                       slot_sel_i,
   input  logic [NUM_UARTS*periph_pkg::HID_DATA_W-1:0] chan_rdata_i,
   output logic [periph_pkg::HID_DATA_W-1:0]           hid_rddata_o
);

   always_comb
   begin
      hid_rddata_o = '0;
      for (int k = 0; k < NUM_UARTS; k++)
      begin
         if (slot_sel_i == periph_pkg::slot_idx_t'(periph_pkg::UART_BASE_SLOT + k))
            hid_rddata_o |= chan_rdata_i[k*periph_pkg::HID_DATA_W +: periph_pkg::HID_DATA_W];
      end
   end

endmodule

// ==== periph_pkg.sv ====
// ======================================
// peripheral bus package
// address and data widths of the CPU-side
// peripheral bus and the one-hot slot map
// ======================================

package periph_pkg;

   localparam int HID_ADDR_W = 18;            // byte address into the peripheral window
   localparam int HID_DATA_W = 64;
   localparam int HID_BE_W   = 8;             // one write enable per byte lane

   localparam int HID_SLOTS  = 8;
   localparam int SLOT_W     = 3;
   localparam int SLOT_MSB   = HID_ADDR_W - 1; // slot sits in the top address bits
   localparam int SLOT_LSB   = HID_ADDR_W - SLOT_W;

   // uart channels fill the slots upward from here
   localparam int UART_BASE_SLOT = 6;

   typedef logic [SLOT_W-1:0] slot_idx_t;

endpackage

// ==== periph_top.sv ====
// ======================================
// peripheral bus top level
// slot decoder, a bank of uart channels
// and the read return multiplexer
// ======================================
`timescale 1ns/1ps

module periph_top #(
   parameter int NUM_UARTS     = 2,
   parameter int FIFO_DEPTH    = 16,
   parameter int UBAUD_DEFAULT = 8
) (
   input  logic                              msoc_clk,
   input  logic                              rstn,
   input  logic                              hid_en_i,
   input  logic [periph_pkg::HID_BE_W-1:0]   hid_we_i,
   input  logic [periph_pkg::HID_ADDR_W-1:0] hid_addr_i,
   input  logic [periph_pkg::HID_DATA_W-1:0] hid_wrdata_i,
   input  logic [NUM_UARTS-1:0]              uart_rx_i,
   output logic [periph_pkg::HID_DATA_W-1:0] hid_rddata_o,
   output logic [NUM_UARTS-1:0]              uart_tx_o,
   output logic [NUM_UARTS-1:0]              uart_irq_o
);

   logic [periph_pkg::HID_SLOTS-1:0]            slot_wr;
   periph_pkg::slot_idx_t                       slot_sel;
   logic [NUM_UARTS*periph_pkg::HID_DATA_W-1:0] chan_rdata;  // channel k at word k

   hid_decode decode_inst (
      .hid_en_i   (hid_en_i),
      .hid_we_i   (hid_we_i),
      .hid_addr_i (hid_addr_i),
      .slot_wr_o  (slot_wr),
      .slot_sel_o (slot_sel)
   );

   for (genvar k = 0; k < NUM_UARTS; k++)
   begin : g_uart
      uart_channel #(
         .FIFO_DEPTH    (FIFO_DEPTH),
         .UBAUD_DEFAULT (UBAUD_DEFAULT)
      ) chan_inst (
         .msoc_clk     (msoc_clk),
         .rstn         (rstn),
         .wr_i         (slot_wr[periph_pkg::UART_BASE_SLOT + k]),
         .hid_addr_i   (hid_addr_i),
         .hid_wrdata_i (hid_wrdata_i),
         .rx_i         (uart_rx_i[k]),
         .tx_o         (uart_tx_o[k]),
         .irq_o        (uart_irq_o[k]),
         .rdata_o      (chan_rdata[k*periph_pkg::HID_DATA_W +: periph_pkg::HID_DATA_W])
      );
   end

   hid_read_mux #(.NUM_UARTS(NUM_UARTS)) read_mux_inst (
      .slot_sel_i   (slot_sel),
      .chan_rdata_i (chan_rdata),
      .hid_rddata_o (hid_rddata_o)
   );

endmodule

// ==== periph_trace.txt ====
# columns: op slot offset data expect (hex); slot 6 is uart 0, slot 7 is uart 1
# ops: wr, rd (compare read word), poll (read until equal), irq (wait level), raw ({stop,byte})
rd   6 0 0   200
rd   7 0 0   200
rd   6 2 0   0
irq  6 0 0   0
irq  7 0 0   0
wr   6 0 5a  0
irq  6 0 0   1
rd   6 0 0   05a
rd   7 0 0   200
irq  7 0 0   0
wr   6 1 0   0
rd   6 0 0   200
irq  6 0 0   0
wr   7 2 c   0
wr   7 0 11  0
wr   7 0 22  0
wr   7 0 33  0
poll 7 2 0   3
rd   7 0 0   011
wr   7 1 0   0
rd   7 2 0   2
rd   7 0 0   022
wr   7 1 0   0
rd   7 2 0   1
rd   7 0 0   033
wr   7 1 0   0
rd   7 2 0   0
rd   7 0 0   200
irq  7 0 0   0
rd   2 0 0   0
rd   2 2 0   0
raw  6 0 0a5 0
irq  6 0 0   1
rd   6 0 0   1a5
wr   6 1 0   0
rd   6 0 0   200

// ==== sources.f ====
periph_pkg.sv
uart_pkg.sv
hid_decode.sv
uart_fifo.sv
uart_serial.sv
uart_channel.sv
hid_read_mux.sv
periph_top.sv
tb_periph.sv

// ==== tb_periph.sv ====
// ========================================
// peripheral bus testbench
// replays bus operations from a trace,
// loops each uart back on itself and can
// bit-bang raw frames into a receiver
// ========================================
`timescale 1ns/1ps

module tb_periph;

   localparam int NUM_UARTS     = 2;
   localparam int UBAUD_DEFAULT = 8;
   localparam int MAX_REC       = 64;
   localparam int OP_WR   = 0;
   localparam int OP_RD   = 1;
   localparam int OP_POLL = 2;
   localparam int OP_IRQ  = 3;
   localparam int OP_RAW  = 4;

   logic                              msoc_clk;
   logic                              rstn;
   logic                              hid_en_i;
   logic [periph_pkg::HID_BE_W-1:0]   hid_we_i;
   logic [periph_pkg::HID_ADDR_W-1:0] hid_addr_i;
   logic [periph_pkg::HID_DATA_W-1:0] hid_wrdata_i;
   logic [periph_pkg::HID_DATA_W-1:0] hid_rddata_o;
   logic [NUM_UARTS-1:0]              uart_rx;
   logic [NUM_UARTS-1:0]              uart_tx_o;
   logic [NUM_UARTS-1:0]              uart_irq_o;
   logic [NUM_UARTS-1:0]              raw_en;     // testbench owns the rx line
   logic [NUM_UARTS-1:0]              raw_line;

   int          rec_op   [MAX_REC];
   int          rec_slot [MAX_REC];
   int          rec_ofs  [MAX_REC];
   logic [63:0] rec_data [MAX_REC];
   logic [63:0] rec_exp  [MAX_REC];
   int          num_rec;
   int          max_div;
   int          chan_div [NUM_UARTS];
   int          err_count;
   bit          trace_ready;

   assign uart_rx = (raw_en & raw_line) | (~raw_en & uart_tx_o);  // loopback unless bit-banging

   periph_top #(
      .NUM_UARTS     (NUM_UARTS),
      .FIFO_DEPTH    (16),
      .UBAUD_DEFAULT (UBAUD_DEFAULT)
   ) periph_top_inst (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en_i),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .uart_rx_i    (uart_rx),
      .hid_rddata_o (hid_rddata_o),
      .uart_tx_o    (uart_tx_o),
      .uart_irq_o   (uart_irq_o)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever #2 msoc_clk = ~msoc_clk;
   end

   function automatic int op_code(input logic [63:0] s);
      case (s)
         "wr":    op_code = OP_WR;
         "rd":    op_code = OP_RD;
         "poll":  op_code = OP_POLL;
         "irq":   op_code = OP_IRQ;
         "raw":   op_code = OP_RAW;
         default: op_code = -1;
      endcase
   endfunction

   function automatic string op_name(input int code);
      case (code)
         OP_WR:   op_name = "write";
         OP_RD:   op_name = "read-check";
         OP_POLL: op_name = "poll";
         OP_IRQ:  op_name = "wait-irq";
         OP_RAW:  op_name = "send-raw";
         default: op_name = "unknown";
      endcase
   endfunction

   // slot in the top bits, register offset in bits 13..12
   function automatic logic [periph_pkg::HID_ADDR_W-1:0] make_addr(input int slot, input int ofs);
      make_addr = '0;
      make_addr[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_W] = slot[periph_pkg::SLOT_W-1:0];
      make_addr[uart_pkg::UART_OFS_LSB +: 2] = ofs[1:0];
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic bus_write(input int slot, input int ofs, input logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i     <= 1'b1;
      hid_we_i     <= '1;
      hid_addr_i   <= make_addr(slot, ofs);
      hid_wrdata_i <= data;
      @(posedge msoc_clk);   // write lands at this edge
      hid_en_i <= 1'b0;
      hid_we_i <= '0;
   endtask

   task automatic bus_read(input int slot, input int ofs, output logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i   <= 1'b1;
      hid_addr_i <= make_addr(slot, ofs);
      @(negedge msoc_clk);   // combinational read, settled mid-cycle
      data = hid_rddata_o;
      @(posedge msoc_clk);
      hid_en_i <= 1'b0;
   endtask

   task automatic send_raw(input int ch, input logic [8:0] stop_byte);
      logic [9:0] frame;
      frame = {stop_byte, 1'b0};   // stop, data, start
      @(negedge msoc_clk);
      check_val("uart_tx_o", 64'(uart_tx_o[ch]), 64'd1);   // own transmitter idles high
      @(posedge msoc_clk);
      raw_en[ch] <= 1'b1;
      for (int i = 0; i < 10; i++)
      begin
         raw_line[ch] <= frame[i];
         repeat (chan_div[ch]) @(posedge msoc_clk);
      end
      raw_line[ch] <= 1'b1;
      repeat (2 * chan_div[ch]) @(posedge msoc_clk);   // idle line before loopback returns
      raw_en[ch] <= 1'b0;
   endtask

   task automatic run_record(input int i);
      logic [63:0] rd;
      int          ch;
      int          n;
      ch = rec_slot[i] - periph_pkg::UART_BASE_SLOT;
      case (rec_op[i])
         OP_WR:
         begin
            bus_write(rec_slot[i], rec_ofs[i], rec_data[i]);
            if (rec_ofs[i] == 2 && ch >= 0 && ch < NUM_UARTS)
               chan_div[ch] = int'(rec_data[i][15:0]);
         end
         OP_RD:
         begin
            bus_read(rec_slot[i], rec_ofs[i], rd);
            check_val("hid_rddata_o", rd, rec_exp[i]);
         end
         OP_POLL:
         begin
            n = 0;
            bus_read(rec_slot[i], rec_ofs[i], rd);
            while (rd !== rec_exp[i] && n < 40 * max_div)
            begin
               bus_read(rec_slot[i], rec_ofs[i], rd);
               n++;
            end
            if (n >= 40 * max_div)
               $display("read word never reached the expected value in time");
            check_val("hid_rddata_o", rd, rec_exp[i]);
         end
         OP_IRQ:
         begin
            n = 0;
            @(negedge msoc_clk);
            while (uart_irq_o[ch] !== rec_exp[i][0] && n < 40 * max_div)
            begin
               @(negedge msoc_clk);
               n++;
            end
            if (n >= 40 * max_div)
               $display("uart_irq_o[%0d] did not reach its level in time", ch);
            check_val("uart_irq_o", 64'(uart_irq_o[ch]), rec_exp[i]);
         end
         OP_RAW:  send_raw(ch, rec_data[i][8:0]);
         default:
         begin
            $display("trace record %0d has an unknown operation", i);
            err_count++;
         end
      endcase
   endtask

   // load the trace, then run one record after the other
   initial
   begin
      int          fd;
      int          n_pass;
      int          n_fail;
      int          err_before;
      int          slot;
      int          ofs;
      logic [63:0] op;
      logic [63:0] data;
      logic [63:0] exp;
      string       line;
      rstn         = 1'b0;
      hid_en_i     = 1'b0;
      hid_we_i     = '0;
      hid_addr_i   = '0;
      hid_wrdata_i = '0;
      raw_en       = '0;
      raw_line     = '1;
      err_count    = 0;
      num_rec      = 0;
      max_div      = UBAUD_DEFAULT;
      n_pass       = 0;
      n_fail       = 0;
      for (int k = 0; k < NUM_UARTS; k++)
         chan_div[k] = UBAUD_DEFAULT;
      fd = $fopen("periph_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the trace file periph_trace.txt");
         $display("Checks failed");
         $finish;
      end
      else
      begin
         while (!$feof(fd) && num_rec < MAX_REC)
         begin
            if ($fgets(line, fd) && line.len() > 1 && line[0] != "#")
            begin
               op = '0;
               if ($sscanf(line, "%s %d %h %h %h", op, slot, ofs, data, exp) == 5)
               begin
                  rec_op[num_rec]   = op_code(op);
                  rec_slot[num_rec] = slot;
                  rec_ofs[num_rec]  = ofs;
                  rec_data[num_rec] = data;
                  rec_exp[num_rec]  = exp;
                  if (rec_op[num_rec] == OP_WR && ofs == 2 && int'(data[15:0]) > max_div)
                     max_div = int'(data[15:0]);
                  num_rec++;
               end
            end
         end
         $fclose(fd);
         trace_ready = 1'b1;
         repeat (4) @(posedge msoc_clk);
         rstn <= 1'b1;
         for (int i = 0; i < num_rec; i++)
         begin
            err_before = err_count;
            run_record(i);
            if (err_count == err_before)
            begin
               n_pass++;
               $display("test %0d %s slot %0d ofs %0d: pass", i, op_name(rec_op[i]),
                        rec_slot[i], rec_ofs[i]);
            end
            else
            begin
               n_fail++;
               $display("test %0d %s slot %0d ofs %0d: fail", i, op_name(rec_op[i]),
                        rec_slot[i], rec_ofs[i]);
            end
         end
         $display("tests run %0d, passed %0d, failed %0d", num_rec, n_pass, n_fail);
         if (n_fail == 0)
            $display("All checks passed");
         else
            $display("Checks failed");
         $finish;
      end
   end

   // bound on the whole run, sized from the trace length and slowest divisor
   initial
   begin
      realtime limit_ns;
      wait (trace_ready);
      limit_ns = num_rec * 12.0 * max_div * 4.0;
      #(limit_ns);
      $display("run did not finish within %0.0f ns, stopped by the watchdog", limit_ns);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== uart_channel.sv ====
// ======================================
// uart channel on one bus slot
// register writes, transmit sequencer,
// tx and rx FIFOs, serial core and the
// status or count read word
// ======================================
`timescale 1ns/1ps

module uart_channel #(
   parameter int FIFO_DEPTH    = 16,
   parameter int UBAUD_DEFAULT = 8
) (
   input  logic                              msoc_clk,
   input  logic                              rstn,
   input  logic                              wr_i,
   input  logic [periph_pkg::HID_ADDR_W-1:0] hid_addr_i,
   input  logic [periph_pkg::HID_DATA_W-1:0] hid_wrdata_i,
   input  logic                              rx_i,
   output logic                              tx_o,
   output logic                              irq_o,
   output logic [periph_pkg::HID_DATA_W-1:0] rdata_o
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   uart_pkg::uart_wdata_u       wdata;
   logic [1:0]                  ofs;
   logic [uart_pkg::BAUD_W-1:0] baud_q;
   uart_pkg::utx_state_t        state_q;
   uart_pkg::utx_state_t        state_d;
   logic [7:0]                  tx_head;
   logic [7:0]                  tx_hold;
   logic [CNT_W-1:0]            tx_count;
   logic                        tx_full;
   logic                        tx_empty;
   logic [8:0]                  rx_head;   // {err, byte}
   logic [CNT_W-1:0]            rx_count;
   logic                        rx_full;
   logic                        rx_empty;
   logic                        busy;
   logic                        rx_valid;
   logic [7:0]                  rx_byte;
   logic                        rx_err;

   assign wdata = hid_wrdata_i;
   assign ofs   = hid_addr_i[uart_pkg::UART_OFS_MSB:uart_pkg::UART_OFS_LSB];

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q  <= uart_pkg::BAUD_W'(UBAUD_DEFAULT);
         state_q <= uart_pkg::UTX_IDLE;
      end
      else
      begin
         state_q <= state_d;
         if (wr_i && ofs == uart_pkg::UART_OFS_BAUD)
            baud_q <= wdata.baud.divisor;
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         uart_pkg::UTX_IDLE:  state_d = uart_pkg::UTX_EMPTY;
         uart_pkg::UTX_EMPTY: if (!tx_empty) state_d = uart_pkg::UTX_POP;
         uart_pkg::UTX_POP:   state_d = uart_pkg::UTX_START;
         uart_pkg::UTX_START: state_d = uart_pkg::UTX_INUSE;
         uart_pkg::UTX_INUSE: if (!busy) state_d = uart_pkg::UTX_IDLE;
         default:             state_d = uart_pkg::UTX_IDLE;
      endcase
   end

   // head moves on at the pop, so keep the byte for START
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == uart_pkg::UTX_POP)
         tx_hold <= tx_head;
   end

   uart_fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (wr_i && ofs == uart_pkg::UART_OFS_TX),
      .pop_i    (state_q == uart_pkg::UTX_POP),
      .din_i    (wdata.tx.data),
      .dout_o   (tx_head),
      .count_o  (tx_count),
      .full_o   (tx_full),
      .empty_o  (tx_empty)
   );

   uart_fifo #(.WIDTH(9), .DEPTH(FIFO_DEPTH)) rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (rx_valid),                               // overflow drops the new byte
      .pop_i    (wr_i && ofs == uart_pkg::UART_OFS_POP),
      .din_i    ({rx_err, rx_byte}),
      .dout_o   (rx_head),
      .count_o  (rx_count),
      .full_o   (rx_full),
      .empty_o  (rx_empty)
   );

   uart_serial serial_inst (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .start_i    (state_q == uart_pkg::UTX_START),
      .tx_byte_i  (tx_hold),
      .rx_i       (rx_i),
      .tx_o       (tx_o),
      .busy_o     (busy),
      .rx_valid_o (rx_valid),
      .rx_byte_o  (rx_byte),
      .rx_err_o   (rx_err)
   );

   assign irq_o = ~rx_empty;

   always_comb
   begin
      rdata_o = '0;
      if (hid_addr_i[uart_pkg::UART_OFS_MSB])
      begin
         rdata_o[uart_pkg::CNT_TX_LSB +: 8] = 8'(tx_count);
         rdata_o[7:0]                       = 8'(rx_count);
      end
      else
      begin
         rdata_o[8:0] = rx_empty ? 9'd0 : rx_head;  // stale head hidden when empty
         rdata_o[uart_pkg::ST_RX_EMPTY_BIT] = rx_empty;
         rdata_o[uart_pkg::ST_TX_FULL_BIT]  = tx_full;
         rdata_o[uart_pkg::ST_RX_FULL_BIT]  = rx_full;
      end
   end

   // POP is only entered from EMPTY with data waiting
   a_pop_not_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      state_q == uart_pkg::UTX_POP |-> !tx_empty);

endmodule

// ==== uart_fifo.sv ====
// ======================================
// synchronous FIFO
// circular buffer with show-ahead head,
// occupancy count, full and empty flags
// ======================================
`timescale 1ns/1ps

module uart_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic                       msoc_clk,
   input  logic                       rstn,
   input  logic                       push_i,
   input  logic                       pop_i,
   input  logic [WIDTH-1:0]           din_i,
   output logic [WIDTH-1:0]           dout_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o,
   output logic                       full_o,
   output logic                       empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i & ~full_o;  // lost when full
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: count_o <= count_o;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din_i;
   end

   assign dout_o  = mem[rd_ptr];  // head entry, no read latency
   assign full_o  = (count_o == CNT_W'(DEPTH));
   assign empty_o = (count_o == '0);

   // occupancy stays bounded over any push/pop sequence
   a_count_bound: assert property (@(posedge msoc_clk) disable iff (!rstn)
      count_o <= CNT_W'(DEPTH));

endmodule

// ==== uart_pkg.sv ====
// ======================================
// uart register package
// register offsets, read word layout,
// sequencer states and write data views
// ======================================

package uart_pkg;

   localparam int BAUD_W = 16;                // clocks per bit

   localparam int UART_OFS_MSB = 13;
   localparam int UART_OFS_LSB = 12;
   localparam logic [1:0] UART_OFS_TX   = 2'd0; // push transmit byte
   localparam logic [1:0] UART_OFS_POP  = 2'd1; // drop receive head
   localparam logic [1:0] UART_OFS_BAUD = 2'd2; // load divisor

   // status word, selected when offset msb is clear
   localparam int ST_ERR_BIT      = 8;
   localparam int ST_RX_EMPTY_BIT = 9;
   localparam int ST_TX_FULL_BIT  = 10;
   localparam int ST_RX_FULL_BIT  = 11;
   localparam int CNT_TX_LSB      = 16;       // count word, tx count field

   typedef enum logic [2:0] {UTX_IDLE, UTX_EMPTY, UTX_POP, UTX_START, UTX_INUSE} utx_state_t;

   // one bus word, seen by the tx push or by the divisor load
   typedef union packed {
      struct packed {
         logic [periph_pkg::HID_DATA_W-9:0] rsvd;
         logic [7:0]                        data;
      } tx;
      struct packed {
         logic [periph_pkg::HID_DATA_W-BAUD_W-1:0] rsvd;
         logic [BAUD_W-1:0]                        divisor;
      } baud;
   } uart_wdata_u;

endpackage

// ==== uart_serial.sv ====
// ======================================
// uart serial core, 8N1
// shift-register transmitter and a
// majority-filtered mid-bit receiver,
// both timed by the baud divisor
// ======================================
`timescale 1ns/1ps

module uart_serial (
   input  logic                        msoc_clk,
   input  logic                        rstn,
   input  logic [uart_pkg::BAUD_W-1:0] baud_i,
   input  logic                        start_i,
   input  logic [7:0]                  tx_byte_i,
   input  logic                        rx_i,
   output logic                        tx_o,
   output logic                        busy_o,
   output logic                        rx_valid_o,
   output logic [7:0]                  rx_byte_o,
   output logic                        rx_err_o
);

   logic [9:0]                  tx_shift;   // stop, data, start
   logic [3:0]                  tx_bits;
   logic [uart_pkg::BAUD_W-1:0] tx_timer;
   logic [2:0]                  rx_filt;
   logic                        rx_maj;
   logic                        rx_active;
   logic [3:0]                  rx_cnt;
   logic [uart_pkg::BAUD_W-1:0] rx_timer;
   logic                        rx_tick;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_shift <= '1;  // line idles high
         tx_bits  <= '0;
         tx_timer <= '0;
      end
      else if (start_i)
      begin
         tx_shift <= {1'b1, tx_byte_i, 1'b0};
         tx_bits  <= 4'd10;
         tx_timer <= baud_i - 1'b1;
      end
      else if (busy_o)
      begin
         if (tx_timer == '0)
         begin
            tx_shift <= {1'b1, tx_shift[9:1]};  // lsb first
            tx_bits  <= tx_bits - 1'b1;
            tx_timer <= baud_i - 1'b1;
         end
         else
            tx_timer <= tx_timer - 1'b1;
      end
   end

   assign tx_o   = tx_shift[0];
   assign busy_o = (tx_bits != 4'd0);

   // three-sample vote against line glitches
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         rx_filt <= '1;
      else
         rx_filt <= {rx_filt[1:0], rx_i};
   end

   assign rx_maj  = (rx_filt[0] & rx_filt[1]) | (rx_filt[0] & rx_filt[2]) |
                    (rx_filt[1] & rx_filt[2]);
   assign rx_tick = rx_active & (rx_timer == '0);  // middle of a bit

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_active  <= 1'b0;
         rx_cnt     <= '0;
         rx_timer   <= '0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_valid_o <= 1'b0;
         if (!rx_active)
         begin
            if (!rx_maj)
            begin
               rx_active <= 1'b1;
               rx_cnt    <= '0;
               rx_timer  <= baud_i >> 1;  // aim at the middle of the start bit
            end
         end
         else if (!rx_tick)
            rx_timer <= rx_timer - 1'b1;
         else
         begin
            rx_timer <= baud_i - 1'b1;
            rx_cnt   <= rx_cnt + 1'b1;
            if (rx_cnt == 4'd0 && rx_maj)
               rx_active <= 1'b0;  // start bit gone, false start
            else if (rx_cnt == 4'd9)
            begin
               rx_active  <= 1'b0;
               rx_valid_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rx_tick && rx_cnt >= 4'd1 && rx_cnt <= 4'd8)
         rx_byte_o <= {rx_maj, rx_byte_o[7:1]};
      if (rx_tick && rx_cnt == 4'd9)
         rx_err_o <= ~rx_maj;  // framing error on low stop bit
   end

   // the channel sequencer only starts a frame once the last one is out
   a_no_start_busy: assert property (@(posedge msoc_clk) disable iff (!rstn)
      start_i |-> !busy_o);

endmodule
